/* compile.f */
+incdir+logic
logic/rs_pkg.sv
logic/station_bank.sv
logic/issue_select.sv
logic/reservation_station.sv
testbench/tb_reservation_station.sv

/* logic/issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module issue_select (
    input  wire                              clk,
    input  wire                              reset,
    input  wire [`RS_SLOTS-1:0]              add_request,
    input  wire [`RS_SLOTS-1:0]              mul_request,
    input  wire rs_pkg::data_t [`RS_SLOTS-1:0] add_op1_vals,
    input  wire rs_pkg::data_t [`RS_SLOTS-1:0] add_op2_vals,
    input  wire rs_pkg::data_t [`RS_SLOTS-1:0] mul_op1_vals,
    input  wire rs_pkg::data_t [`RS_SLOTS-1:0] mul_op2_vals,
    output logic [`RS_SLOTS-1:0]             add_grant,
    output logic [`RS_SLOTS-1:0]             mul_grant,
    output rs_pkg::data_t                    rs1_val,
    output rs_pkg::data_t                    rs2_val,
    output rs_pkg::row_tag_u                 row,
    output logic                             calculate
);
    import rs_pkg::*;

    localparam int ROWS  = `RS_BANKS * `RS_SLOTS;
    localparam int ROW_W = $clog2(ROWS);

    logic [ROWS-1:0]   req_all;   // adder rows in the low half
    logic [ROWS-1:0]   grant_oh;
    logic [ROW_W-1:0]  pick;      // lowest requesting row
    logic              any_req;
    data_t [ROWS-1:0]  op1_all;
    data_t [ROWS-1:0]  op2_all;
    row_tag_u          pick_tag;

    assign req_all = {mul_request, add_request};
    assign op1_all = {mul_op1_vals, add_op1_vals};
    assign op2_all = {mul_op2_vals, add_op2_vals};
    assign any_req = |req_all;

    // oldest ready means lowest row number
    always_comb begin
        pick = '0;
        for (int i = ROWS - 1; i >= 0; i--) begin
            if (req_all[i]) begin
                pick = ROW_W'(i);
            end
        end
    end

    assign grant_oh  = any_req ? (ROWS'(1) << pick) : '0;
    assign add_grant = grant_oh[`RS_SLOTS-1:0];
    assign mul_grant = grant_oh[ROWS-1:`RS_SLOTS];

    always_comb begin
        pick_tag.f.spare = 1'b0;
        pick_tag.f.bank  = pick[SLOT_W];   // upper half is the multiplier
        pick_tag.f.slot  = pick[SLOT_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            calculate <= 1'b0;
            rs1_val   <= '0;
            rs2_val   <= '0;
            row       <= '0;
        end else begin
            calculate <= any_req;        // one pulse per granted row
            if (any_req) begin
                rs1_val <= op1_all[pick];
                rs2_val <= op2_all[pick];
                row     <= pick_tag;     // FU broadcasts this tag when done
            end
        end
    end

endmodule

`default_nettype wire

/* logic/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module reservation_station (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      dispatch,
    input  wire                      dispatch_is_mul,
    input  wire rs_pkg::data_t       src1_value,
    input  wire rs_pkg::data_t       src2_value,
    input  wire rs_pkg::row_tag_u    src1_tag,
    input  wire rs_pkg::row_tag_u    src2_tag,
    input  wire                      src1_ready,
    input  wire                      src2_ready,
    input  wire                      add_bc_valid,
    input  wire rs_pkg::row_tag_u    add_bc_tag,
    input  wire rs_pkg::data_t       add_bc_value,
    input  wire                      mul_bc_valid,
    input  wire rs_pkg::row_tag_u    mul_bc_tag,
    input  wire rs_pkg::data_t       mul_bc_value,
    input  wire                      free_valid,
    input  wire rs_pkg::row_tag_u    free_tag,
    output rs_pkg::row_tag_u         available,
    output logic                     add_full,
    output logic                     mul_full,
    output rs_pkg::data_t            rs1_val,
    output rs_pkg::data_t            rs2_val,
    output rs_pkg::row_tag_u         row,
    output logic                     calculate
);
    import rs_pkg::*;

    logic                       add_dispatch_en;
    logic                       mul_dispatch_en;
    row_tag_u                   add_free_row;  // lowest free adder row
    row_tag_u                   mul_free_row;
    logic [`RS_SLOTS-1:0]       add_request;
    logic [`RS_SLOTS-1:0]       mul_request;
    logic [`RS_SLOTS-1:0]       add_grant;
    logic [`RS_SLOTS-1:0]       mul_grant;
    data_t [`RS_SLOTS-1:0]      add_op1_vals;
    data_t [`RS_SLOTS-1:0]      add_op2_vals;
    data_t [`RS_SLOTS-1:0]      mul_op1_vals;
    data_t [`RS_SLOTS-1:0]      mul_op2_vals;

    // steer the strobe to one bank, full check lives in the bank
    assign add_dispatch_en = dispatch && (dispatch_is_mul == BANK_ADD);
    assign mul_dispatch_en = dispatch && (dispatch_is_mul == BANK_MUL);

    assign available = (dispatch_is_mul == BANK_MUL) ? mul_free_row : add_free_row;

    station_bank #(.BANK(BANK_ADD)) u_add_bank (
        .clk          (clk),
        .reset        (reset),
        .dispatch_en  (add_dispatch_en),
        .src1_value   (src1_value),
        .src1_tag     (src1_tag),
        .src1_ready   (src1_ready),
        .src2_value   (src2_value),
        .src2_tag     (src2_tag),
        .src2_ready   (src2_ready),
        .add_bc_valid (add_bc_valid),
        .add_bc_tag   (add_bc_tag),
        .add_bc_value (add_bc_value),
        .mul_bc_valid (mul_bc_valid),
        .mul_bc_tag   (mul_bc_tag),
        .mul_bc_value (mul_bc_value),
        .free_valid   (free_valid),
        .free_tag     (free_tag),
        .grant        (add_grant),
        .free_row     (add_free_row),
        .full         (add_full),
        .request      (add_request),
        .op1_vals     (add_op1_vals),
        .op2_vals     (add_op2_vals)
    );

    station_bank #(.BANK(BANK_MUL)) u_mul_bank (
        .clk          (clk),
        .reset        (reset),
        .dispatch_en  (mul_dispatch_en),
        .src1_value   (src1_value),
        .src1_tag     (src1_tag),
        .src1_ready   (src1_ready),
        .src2_value   (src2_value),
        .src2_tag     (src2_tag),
        .src2_ready   (src2_ready),
        .add_bc_valid (add_bc_valid),
        .add_bc_tag   (add_bc_tag),
        .add_bc_value (add_bc_value),
        .mul_bc_valid (mul_bc_valid),
        .mul_bc_tag   (mul_bc_tag),
        .mul_bc_value (mul_bc_value),
        .free_valid   (free_valid),
        .free_tag     (free_tag),
        .grant        (mul_grant),
        .free_row     (mul_free_row),
        .full         (mul_full),
        .request      (mul_request),
        .op1_vals     (mul_op1_vals),
        .op2_vals     (mul_op2_vals)
    );

    // one issue per cycle across both banks
    issue_select u_issue (
        .clk          (clk),
        .reset        (reset),
        .add_request  (add_request),
        .mul_request  (mul_request),
        .add_op1_vals (add_op1_vals),
        .add_op2_vals (add_op2_vals),
        .mul_op1_vals (mul_op1_vals),
        .mul_op2_vals (mul_op2_vals),
        .add_grant    (add_grant),
        .mul_grant    (mul_grant),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .row          (row),
        .calculate    (calculate)
    );

endmodule

`default_nettype wire

/* logic/rs_defines.svh */
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// operand word
`define RS_DATA_W 32

// row tag, {spare, bank, slot}
`define RS_TAG_W 4

// rows per functional unit
`define RS_SLOTS 4

// adder bank and multiplier bank
`define RS_BANKS 2

`endif

/* logic/rs_pkg.sv */
`default_nettype none

`include "rs_defines.svh"

package rs_pkg;

    localparam int SLOT_W = $clog2(`RS_SLOTS);  // slot index bits

    typedef logic [`RS_DATA_W-1:0] data_t;       // operand / result word

    // field view of a row tag
    typedef struct packed {
        logic              spare;  // always zero
        logic              bank;   // 0 adder, 1 multiplier
        logic [SLOT_W-1:0] slot;   // row inside the bank
    } row_fields_t;

    // same 4 bits, raw for compares, fields for routing
    typedef union packed {
        logic [`RS_TAG_W-1:0] raw;
        row_fields_t          f;
    } row_tag_u;

    localparam logic BANK_ADD = 1'b0;
    localparam logic BANK_MUL = 1'b1;

endpackage

`default_nettype wire

/* logic/station_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module station_bank #(
    parameter logic BANK = rs_pkg::BANK_ADD  // bank bit this instance answers to
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              dispatch_en,
    input  wire rs_pkg::data_t               src1_value,
    input  wire rs_pkg::row_tag_u            src1_tag,
    input  wire                              src1_ready,
    input  wire rs_pkg::data_t               src2_value,
    input  wire rs_pkg::row_tag_u            src2_tag,
    input  wire                              src2_ready,
    input  wire                              add_bc_valid,
    input  wire rs_pkg::row_tag_u            add_bc_tag,
    input  wire rs_pkg::data_t               add_bc_value,
    input  wire                              mul_bc_valid,
    input  wire rs_pkg::row_tag_u            mul_bc_tag,
    input  wire rs_pkg::data_t               mul_bc_value,
    input  wire                              free_valid,
    input  wire rs_pkg::row_tag_u            free_tag,
    input  wire [`RS_SLOTS-1:0]              grant,
    output rs_pkg::row_tag_u                 free_row,
    output logic                             full,
    output logic [`RS_SLOTS-1:0]             request,
    output rs_pkg::data_t [`RS_SLOTS-1:0]    op1_vals,
    output rs_pkg::data_t [`RS_SLOTS-1:0]    op2_vals
);
    import rs_pkg::*;

    logic [`RS_SLOTS-1:0]     busy;       // row holds an instruction
    logic [`RS_SLOTS-1:0]     issued;     // sent to the FU, waiting on free
    logic [`RS_SLOTS-1:0]     op1_valid;
    logic [`RS_SLOTS-1:0]     op2_valid;
    row_tag_u [`RS_SLOTS-1:0] op1_tag;    // producer row while waiting
    row_tag_u [`RS_SLOTS-1:0] op2_tag;

    logic [SLOT_W-1:0]        free_slot;
    logic [`RS_SLOTS-1:0]     alloc;      // one-hot row write
    logic [`RS_SLOTS-1:0]     free_hit;
    logic [`RS_SLOTS-1:0]     add_hit1;   // waiting op1 sees adder result
    logic [`RS_SLOTS-1:0]     mul_hit1;
    logic [`RS_SLOTS-1:0]     add_hit2;
    logic [`RS_SLOTS-1:0]     mul_hit2;

    logic                     src1_add_hit;
    logic                     src1_mul_hit;
    logic                     src2_add_hit;
    logic                     src2_mul_hit;
    logic                     src1_now;   // op1 valid at write
    logic                     src2_now;
    data_t                    src1_data;
    data_t                    src2_data;

    function automatic logic tag_hit(input logic bc_valid, input row_tag_u bc_tag,
                                     input row_tag_u tag);
        return bc_valid && (bc_tag.raw == tag.raw);
    endfunction

    // scan top down so the lowest free row is left standing
    always_comb begin
        free_slot = '0;
        for (int i = `RS_SLOTS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = SLOT_W'(i);
            end
        end
    end

    assign full = &busy;

    always_comb begin
        free_row.f.spare = 1'b0;
        free_row.f.bank  = BANK;
        free_row.f.slot  = free_slot;  // meaningless while full
    end

    always_comb begin
        for (int i = 0; i < `RS_SLOTS; i++) begin
            alloc[i]    = dispatch_en && !full && (free_slot == SLOT_W'(i));
            free_hit[i] = free_valid && (free_tag.f.bank == BANK)
                          && (free_tag.f.slot == SLOT_W'(i));
            // only waiting operands of live rows snoop
            add_hit1[i] = busy[i] && !op1_valid[i]
                          && tag_hit(add_bc_valid, add_bc_tag, op1_tag[i]);
            mul_hit1[i] = busy[i] && !op1_valid[i]
                          && tag_hit(mul_bc_valid, mul_bc_tag, op1_tag[i]);
            add_hit2[i] = busy[i] && !op2_valid[i]
                          && tag_hit(add_bc_valid, add_bc_tag, op2_tag[i]);
            mul_hit2[i] = busy[i] && !op2_valid[i]
                          && tag_hit(mul_bc_valid, mul_bc_tag, op2_tag[i]);
        end
    end

    // dispatch-cycle capture, adder result first
    assign src1_add_hit = tag_hit(add_bc_valid, add_bc_tag, src1_tag);
    assign src1_mul_hit = tag_hit(mul_bc_valid, mul_bc_tag, src1_tag);
    assign src2_add_hit = tag_hit(add_bc_valid, add_bc_tag, src2_tag);
    assign src2_mul_hit = tag_hit(mul_bc_valid, mul_bc_tag, src2_tag);

    assign src1_now  = src1_ready || src1_add_hit || src1_mul_hit;
    assign src2_now  = src2_ready || src2_add_hit || src2_mul_hit;
    assign src1_data = src1_ready ? src1_value : (src1_add_hit ? add_bc_value : mul_bc_value);
    assign src2_data = src2_ready ? src2_value : (src2_add_hit ? add_bc_value : mul_bc_value);

    assign request = busy & op1_valid & op2_valid & ~issued;  // ready, not yet sent

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= '0;
            issued    <= '0;
            op1_valid <= '0;
            op2_valid <= '0;
        end else begin
            for (int i = 0; i < `RS_SLOTS; i++) begin
                if (alloc[i]) begin
                    busy[i]      <= 1'b1;
                    issued[i]    <= 1'b0;
                    op1_valid[i] <= src1_now;
                    op2_valid[i] <= src2_now;
                end else begin
                    if (add_hit1[i] || mul_hit1[i]) begin
                        op1_valid[i] <= 1'b1;
                    end
                    if (add_hit2[i] || mul_hit2[i]) begin
                        op2_valid[i] <= 1'b1;
                    end
                    if (grant[i]) begin
                        issued[i] <= 1'b1;
                    end
                end
                // FU done with this row
                if (free_hit[i]) begin
                    busy[i]      <= 1'b0;
                    issued[i]    <= 1'b0;
                    op1_valid[i] <= 1'b0;
                    op2_valid[i] <= 1'b0;
                end
            end
        end
    end

    // operand values and producer tags
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_SLOTS; i++) begin
            if (alloc[i]) begin
                op1_vals[i] <= src1_data;
                op2_vals[i] <= src2_data;
                op1_tag[i]  <= src1_tag;
                op2_tag[i]  <= src2_tag;
            end else begin
                if (add_hit1[i]) begin
                    op1_vals[i] <= add_bc_value;
                end else if (mul_hit1[i]) begin
                    op1_vals[i] <= mul_bc_value;
                end
                if (add_hit2[i]) begin
                    op2_vals[i] <= add_bc_value;
                end else if (mul_hit2[i]) begin
                    op2_vals[i] <= mul_bc_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_reservation_station --Mdir obj_dir -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

/* testbench/tb_reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rs_defines.svh"

module tb_reservation_station;
    import rs_pkg::*;

    localparam int ROWS = `RS_BANKS * `RS_SLOTS;

    logic     clk;
    logic     reset;
    logic     dispatch;
    logic     dispatch_is_mul;
    data_t    src1_value;
    data_t    src2_value;
    row_tag_u src1_tag;
    row_tag_u src2_tag;
    logic     src1_ready;
    logic     src2_ready;
    logic     add_bc_valid;
    row_tag_u add_bc_tag;
    data_t    add_bc_value;
    logic     mul_bc_valid;
    row_tag_u mul_bc_tag;
    data_t    mul_bc_value;
    logic     free_valid;
    row_tag_u free_tag;
    row_tag_u available;
    logic     add_full;
    logic     mul_full;
    data_t    rs1_val;
    data_t    rs2_val;
    row_tag_u row_out;
    logic     calculate;

    // reference rows, adder 0..3 then multiplier 4..7
    logic       m_busy [ROWS];
    logic       m_issued [ROWS];
    logic       m_v1 [ROWS];
    logic       m_v2 [ROWS];
    data_t      m_val1 [ROWS];
    data_t      m_val2 [ROWS];
    logic [3:0] m_tag1 [ROWS];
    logic [3:0] m_tag2 [ROWS];

    logic       exp_calc;      // predicted issue after the last edge
    logic [3:0] exp_row;
    data_t      exp_v1;
    data_t      exp_v2;
    int         issue_total;   // calculate pulses seen
    int         issues_wanted;
    int         row_issues [ROWS];
    logic [3:0] last_row;
    data_t      last_v1;
    data_t      last_v2;
    logic [3:0] avail_seen;    // available at the last dispatch
    int         seed = 32'h18043d0c;

    reservation_station u_dut (
        .clk (clk), .reset (reset), .dispatch (dispatch), .dispatch_is_mul (dispatch_is_mul),
        .src1_value (src1_value), .src2_value (src2_value),
        .src1_tag (src1_tag), .src2_tag (src2_tag),
        .src1_ready (src1_ready), .src2_ready (src2_ready),
        .add_bc_valid (add_bc_valid), .add_bc_tag (add_bc_tag), .add_bc_value (add_bc_value),
        .mul_bc_valid (mul_bc_valid), .mul_bc_tag (mul_bc_tag), .mul_bc_value (mul_bc_value),
        .free_valid (free_valid), .free_tag (free_tag),
        .available (available), .add_full (add_full), .mul_full (mul_full),
        .rs1_val (rs1_val), .rs2_val (rs2_val), .row (row_out), .calculate (calculate)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "check failed");
    endtask

    // lowest free slot of a bank, -1 when full
    function automatic int lowest_free(input logic bank);
        int found;
        found = -1;
        for (int s = `RS_SLOTS - 1; s >= 0; s--) begin
            if (!m_busy[(bank ? `RS_SLOTS : 0) + s]) begin
                found = s;
            end
        end
        return found;
    endfunction

    // waiting operand vs both results, adder first
    task automatic snoop(inout logic v, inout data_t val, input logic [3:0] tag);
        if (!v && add_bc_valid && add_bc_tag.raw == tag) begin
            v   = 1'b1;
            val = add_bc_value;
        end else if (!v && mul_bc_valid && mul_bc_tag.raw == tag) begin
            v   = 1'b1;
            val = mul_bc_value;
        end
    endtask

    always @(posedge clk) begin : row_model
        int pick;
        int slot;
        int r;
        if (reset) begin
            for (int i = 0; i < ROWS; i++) begin
                m_busy[i]   = 1'b0;
                m_issued[i] = 1'b0;
                m_v1[i]     = 1'b0;
                m_v2[i]     = 1'b0;
            end
            exp_calc = 1'b0;
        end else begin
            pick = -1;
            for (int i = ROWS - 1; i >= 0; i--) begin
                if (m_busy[i] && m_v1[i] && m_v2[i] && !m_issued[i]) begin
                    pick = i;  // oldest ready row
                end
            end
            exp_calc = (pick >= 0);
            if (pick >= 0) begin
                exp_row        = 4'(pick);
                exp_v1         = m_val1[pick];
                exp_v2         = m_val2[pick];
                m_issued[pick] = 1'b1;
            end
            slot = dispatch ? lowest_free(dispatch_is_mul) : -1;  // full bank drops it
            for (int i = 0; i < ROWS; i++) begin
                if (m_busy[i]) begin
                    snoop(m_v1[i], m_val1[i], m_tag1[i]);
                    snoop(m_v2[i], m_val2[i], m_tag2[i]);
                end
            end
            if (free_valid) begin
                r = int'(free_tag.raw[2:0]);
                m_busy[r]   = 1'b0;
                m_issued[r] = 1'b0;
            end
            if (slot >= 0) begin
                r = (dispatch_is_mul ? `RS_SLOTS : 0) + slot;
                m_busy[r]   = 1'b1;
                m_issued[r] = 1'b0;
                m_tag1[r]   = src1_tag.raw;
                m_tag2[r]   = src2_tag.raw;
                m_v1[r]     = src1_ready;
                m_val1[r]   = src1_value;
                m_v2[r]     = src2_ready;
                m_val2[r]   = src2_value;
                snoop(m_v1[r], m_val1[r], m_tag1[r]);  // same-cycle capture
                snoop(m_v2[r], m_val2[r], m_tag2[r]);
            end
        end
    end

    // registered outputs settle long before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            assert (calculate == exp_calc)
                else stop_on_error($sformatf("calculate %0b, expected %0b", calculate, exp_calc));
            if (calculate) begin
                assert (row_out.raw == exp_row && rs1_val == exp_v1 && rs2_val == exp_v2)
                    else stop_on_error($sformatf("issue row %0h %0h %0h, expected %0h %0h %0h",
                        row_out.raw, rs1_val, rs2_val, exp_row, exp_v1, exp_v2));
                issue_total++;
                row_issues[row_out.raw[2:0]]++;
                last_row = row_out.raw;
                last_v1  = rs1_val;
                last_v2  = rs2_val;
            end
            assert (add_full == (lowest_free(1'b0) < 0) && mul_full == (lowest_free(1'b1) < 0))
                else stop_on_error($sformatf("full flags %0b %0b wrong", add_full, mul_full));
        end
    end

    spare_bit_zero: assert property (@(posedge clk) disable iff (reset)
        !available.f.spare && (!calculate || !row_out.f.spare))
        else stop_on_error("spare tag bit set on available or row");

    task automatic drive_idle();
        dispatch        = 1'b0;
        dispatch_is_mul = 1'b0;
        src1_value      = '0;
        src2_value      = '0;
        src1_tag        = '0;
        src2_tag        = '0;
        src1_ready      = 1'b0;
        src2_ready      = 1'b0;
        add_bc_valid    = 1'b0;
        add_bc_tag      = '0;
        add_bc_value    = '0;
        mul_bc_valid    = 1'b0;
        mul_bc_tag      = '0;
        mul_bc_value    = '0;
        free_valid      = 1'b0;
        free_tag        = '0;
    endtask

    task automatic set_dispatch(input logic is_mul, input data_t v1, input logic [3:0] t1,
                                input logic r1, input data_t v2, input logic [3:0] t2,
                                input logic r2);
        dispatch        = 1'b1;
        dispatch_is_mul = is_mul;
        src1_value      = v1;
        src1_tag.raw    = t1;
        src1_ready      = r1;
        src2_value      = v2;
        src2_tag.raw    = t2;
        src2_ready      = r2;
    endtask

    task automatic set_broadcast(input data_t av, input logic [3:0] at, input data_t mv,
                                 input logic [3:0] mt);
        add_bc_valid   = 1'b1;
        add_bc_tag.raw = at;
        add_bc_value   = av;
        mul_bc_valid   = 1'b1;
        mul_bc_tag.raw = mt;
        mul_bc_value   = mv;
    endtask

    task automatic set_free(input logic [3:0] tag);
        free_valid   = 1'b1;
        free_tag.raw = tag;
    endtask

    task automatic check_available(input logic is_mul, input logic [3:0] expected);
        dispatch_is_mul = is_mul;
        #1;
        assert (available.raw == expected)
            else stop_on_error($sformatf("available %0h, expected %0h", available.raw, expected));
        @(negedge clk);
    endtask

    // one clock with the inputs set so far, then back to idle
    task automatic step();
        #1;
        if (dispatch && lowest_free(dispatch_is_mul) >= 0) begin
            avail_seen = {1'b0, dispatch_is_mul, 2'(lowest_free(dispatch_is_mul))};
            assert (available.raw == avail_seen)
                else stop_on_error($sformatf("available %0h, expected %0h",
                    available.raw, avail_seen));
        end
        @(negedge clk);
        drive_idle();
    endtask

    // block until n more calculate pulses, watchdog bounds it
    task automatic wait_issues(input int n);
        issues_wanted += n;
        while (issue_total < issues_wanted) @(posedge clk);
        @(negedge clk);
    endtask

    initial begin
        repeat (400) @(posedge clk);  // about five times the directed tests
        $display("Timeout: the tests did not finish within 400 clock cycles");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        data_t a;
        data_t b;
        reset         = 1'b1;
        issue_total   = 0;
        issues_wanted = 0;
        drive_idle();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        assert (!calculate && !add_full && !mul_full && row_out.raw == 4'h0
                && rs1_val == '0 && rs2_val == '0)
            else stop_on_error("outputs not idle after reset");
        check_available(1'b0, 4'h0);
        check_available(1'b1, 4'h4);

        for (int bank = 0; bank < 2; bank++) begin
            a = $random(seed);
            b = $random(seed);
            set_dispatch(1'(bank), a, 4'h0, 1'b1, b, 4'h0, 1'b1);
            step();
            wait_issues(1);
            assert (last_row == avail_seen && last_v1 == a && last_v2 == b)
                else stop_on_error($sformatf("ready dispatch into bank %0d issued wrong", bank));
            set_free(avail_seen);
            step();
        end

        // row 0 waits on the mul result, row 1 on the add result
        a = $random(seed);
        b = $random(seed);
        set_dispatch(1'b0, $random(seed), 4'h5, 1'b0, $random(seed), 4'h0, 1'b1);
        step();
        set_dispatch(1'b0, $random(seed), 4'h0, 1'b1, $random(seed), 4'h2, 1'b0);
        step();
        set_broadcast(a, 4'h2, b, 4'h5);
        set_dispatch(1'b1, $random(seed), 4'h2, 1'b0, $random(seed), 4'h5, 1'b0);
        step();
        wait_issues(3);
        assert (last_row == 4'h4 && last_v1 == a && last_v2 == b)
            else stop_on_error("same-cycle capture at dispatch lost the broadcast");
        set_free(4'h0);
        step();
        set_free(4'h1);
        step();
        set_free(4'h4);
        step();

        // six rows released by one cycle of broadcasts
        for (int k = 0; k < ROWS; k++) begin
            row_issues[k] = 0;
        end
        for (int k = 0; k < 4; k++) begin
            set_dispatch(1'b0, $random(seed), 4'h0, 1'b1, $random(seed), 4'h7, 1'b0);
            step();
        end
        for (int k = 0; k < 2; k++) begin
            set_dispatch(1'b1, $random(seed), 4'h7, 1'b0, $random(seed), 4'h3, 1'b0);
            step();
        end
        set_broadcast($random(seed), 4'h3, $random(seed), 4'h7);
        step();
        wait_issues(6);
        for (int k = 0; k < ROWS; k++) begin
            assert (row_issues[k] == ((k < 6) ? 1 : 0))
                else stop_on_error($sformatf("row %0d issued %0d times", k, row_issues[k]));
        end
        for (int k = 0; k < 6; k++) begin
            set_free(4'(k));
            step();
        end

        // fill the adder bank with rows that never complete
        for (int k = 0; k < 4; k++) begin
            set_dispatch(1'b0, $random(seed), 4'h6, 1'b0, $random(seed), 4'h6, 1'b0);
            step();
        end
        assert (add_full) else stop_on_error("add_full low after four dispatches");
        set_dispatch(1'b0, $random(seed), 4'h0, 1'b1, $random(seed), 4'h0, 1'b1);
        step();
        assert (add_full) else stop_on_error("dispatch into a full bank was taken");
        set_free(4'h2);
        step();
        assert (!add_full) else stop_on_error("add_full still high after freeing row 2");
        check_available(1'b0, 4'h2);
        a = $random(seed);
        b = $random(seed);
        set_dispatch(1'b0, a, 4'h0, 1'b1, b, 4'h0, 1'b1);
        step();
        wait_issues(1);
        assert (last_row == 4'h2 && last_v1 == a && last_v2 == b)
            else stop_on_error("dispatch after free did not fill row 2");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
